// File: verif/lsu_vectors.txt
// hex fields: mem_op rd_idx rs1 rs2 imm expected_kind expected_data
// mem_op 1-7 loads, 8-b stores, 0 none; kind 0 load_data, 1 store_ack, 2 fault
b 01 100 8877665544332211 8 1 0
7 02 100 0 8 0 8877665544332211
a 03 110 1234567889abcdef 0 1 0
5 04 110 0 0 0 ffffffff89abcdef
6 05 110 0 0 0 0000000089abcdef
a 06 110 7fedcba9 4 1 0
7 07 110 0 0 0 7fedcba989abcdef
9 08 118 beef8001 2 1 0
3 09 118 0 2 0 ffffffffffff8001
4 0a 118 0 2 0 0000000000008001
8 0b 118 a5 7 1 0
1 0c 118 0 7 0 ffffffffffffffa5
2 0d 118 0 7 0 00000000000000a5
7 0e 118 0 0 0 a500000080010000
b 0f 200 0123456789abcdef 0 1 0
8 10 200 5a 3 1 0
8 11 200 c3 6 1 0
7 12 200 0 0 0 01c345675aabcdef
5 13 200 0 4 0 0000000001c34567
9 14 200 ffff 1 2 201
a 15 200 ffffffff 2 2 202
7 16 200 0 4 2 204
b 17 200 ffffffffffffffff 3 2 203
7 18 200 0 0 0 01c345675aabcdef
b 19 3f8 1111111111111111 8 2 400
7 1a 0 0 fffffffffffffff8 2 fffffffffffffff8
1 1b 400 0 0 2 400
7 1c 0 0 0 0 0
0 1d 100 0 0 2 100
7 1f 3f8 0 0 0 0

// File: build.f
src/lsu_pkg.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/lsu_mem_access.sv
src/lsu_result.sv
src/data_ram_apb.sv
src/lsu_top.sv
verif/tb_clock_gen.sv
verif/lsu_properties.sv
verif/lsu_tb.sv

// File: verif/lsu_tb.sv
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int unsigned ram_addr_bits = 10;
  localparam int unsigned ram_words     = 2 ** (ram_addr_bits - 3);
  localparam int unsigned vec_fields    = 7;
  localparam int unsigned max_vecs      = 64;
  localparam int          wait_limit    = 40;
  localparam int          random_pairs  = 20;
  localparam xlen_t       no_entry      = '1;

  logic      clk;
  logic      arst_n;
  logic      issue_valid;
  logic      issue_ready;
  lsu_req_t  issue_req;
  logic      resp_valid;
  lsu_resp_t resp;

  xlen_t     vec_mem [vec_fields*max_vecs];
  xlen_t     model [ram_words];   // expected RAM words for the random phase
  int        errors;
  int        tests;
  int        seed;
  logic      timed_out;

  tb_clock_gen #(.half_period(50), .reset_cycles(16)) u_clock (.clk(clk), .arst_n(arst_n));

  lsu_top #(
    .ram_addr_bits (ram_addr_bits)
  ) dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_req   (issue_req),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

  bind lsu_top lsu_properties u_properties (
    .clk (clk), .arst_n (arst_n), .issue_ready (issue_ready), .resp_valid (resp_valid),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .pstrb (pstrb)
  );

  // ##############################
  // checks
  // ##############################

  task automatic check_kind(input string name, input resp_kind_e got, input resp_kind_e exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // issues one operation alone and waits for its response
  task automatic run_op(input lsu_req_t req, input resp_kind_e exp_kind, input xlen_t exp_data);
    int    waited;
    int    edges;
    int    errs_before;
    logic  seen;
    xlen_t exp_lat;

    errs_before = errors;
    tests++;
    exp_lat = (exp_kind == resp_fault) ? 2 : 4;   // a fault skips both APB cycles
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_req   <= req;
    waited = 0;
    @(negedge clk);
    while (!issue_ready && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!issue_ready) begin
      $display("test %0d: issue_ready stayed low for %0d cycles, operation never accepted",
               tests, waited);
      timed_out = 1'b1;
      return;
    end
    @(posedge clk);   // accepting edge
    issue_valid <= 1'b0;
    edges = 0;
    seen  = 1'b0;
    while (!seen && edges < wait_limit) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      seen = resp_valid;
    end
    if (!seen) begin
      $display("test %0d: no response within %0d cycles of the accepting edge", tests, edges);
      timed_out = 1'b1;
      return;
    end
    check_kind("resp.kind", resp.kind, exp_kind);
    check_data("resp.rd_idx", xlen_t'(resp.rd_idx), xlen_t'(req.rd_idx));
    check_data("resp.data", resp.data, exp_data);
    check_data("latency", xlen_t'(edges), exp_lat);
    $display("test %0d %s rd=%0d addr=%h: %s", tests, req.mem_op.name(), req.rd_idx,
             req.rs1_data + req.imm, (errors == errs_before) ? "ok" : "mismatch");
  endtask

  // ##############################
  // sequence
  // ##############################

  initial begin
    lsu_req_t req;
    xlen_t    addr;
    xlen_t    wdata;
    xlen_t    written [$];
    int       n;
    int       k;
    int       idx;
    int       pick;
    int       waited;

    issue_valid = 1'b0;
    issue_req   = '0;
    errors      = 0;
    tests       = 0;
    timed_out   = 1'b0;
    seed        = 33520;
    for (n = 0; n < vec_fields * max_vecs; n++) begin
      vec_mem[n] = no_entry;   // marks the end of the file
    end
    $readmemh("verif/lsu_vectors.txt", vec_mem);

    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (arst_n !== 1'b1 && waited < 40);
    if (arst_n !== 1'b1) begin
      $display("reset was never released");
      timed_out = 1'b1;
    end

    n = 0;
    while (!timed_out && n < max_vecs && vec_mem[n*vec_fields] != no_entry) begin
      req.mem_op   = mem_op_e'(vec_mem[n*vec_fields][3:0]);
      req.rd_idx   = vec_mem[n*vec_fields+1][reg_idx_bits-1:0];
      req.rs1_data = vec_mem[n*vec_fields+2];
      req.rs2_data = vec_mem[n*vec_fields+3];
      req.imm      = vec_mem[n*vec_fields+4];
      run_op(req, resp_kind_e'(vec_mem[n*vec_fields+5][1:0]), vec_mem[n*vec_fields+6]);
      n++;
    end
    if (n == 0) begin
      $display("no operations were read from verif/lsu_vectors.txt");
      errors++;
    end

    // stores to random words, each followed by a load of some word already stored
    for (k = 0; k < random_pairs && !timed_out; k++) begin
      idx   = $unsigned($random(seed)) % ram_words;
      addr  = xlen_t'(idx) << 3;
      wdata = {$random(seed), $random(seed)};
      model[idx] = wdata;
      written.push_back(addr);
      req = '0;
      req.mem_op   = op_sd;
      req.rd_idx   = reg_idx_bits'(k);
      req.rs1_data = addr;
      req.rs2_data = wdata;
      run_op(req, resp_store_ack, '0);
      pick = $unsigned($random(seed)) % written.size();
      addr = written[pick];
      req  = '0;
      req.mem_op   = op_ld;
      req.rd_idx   = reg_idx_bits'(k + random_pairs);
      req.rs1_data = addr;
      if (!timed_out) begin
        run_op(req, resp_load_data, model[addr[ram_addr_bits-1:3]]);
      end
    end

    errors += dut.u_properties.failures;
    $display("%0d tests run, %0d errors, %0d assertion failures", tests, errors,
             dut.u_properties.failures);
    if (errors == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/lsu_properties.sv
`default_nettype none

module lsu_properties (
  input logic                          clk,
  input logic                          arst_n,
  input logic                          issue_ready,
  input logic                          resp_valid,
  input logic                          psel,
  input logic                          penable,
  input logic                          pwrite,
  input lsu_pkg::xlen_t                paddr,
  input lsu_pkg::xlen_t                pwdata,
  input logic [lsu_pkg::strb_bits-1:0] pstrb
);

  int unsigned failures = 0;   // read by the testbench at the end of the run

  // ACCESS is only entered from a SETUP cycle
  assert property (@(posedge clk) disable iff (!arst_n)
    $rose(penable) |-> $past(psel && !penable))
    else begin
      failures++;
      $error("penable rose without a preceding SETUP cycle");
    end

  assert property (@(posedge clk) disable iff (!arst_n)
    (psel && !penable) |=> (psel && penable && $stable(pwrite) && $stable(paddr)
                            && $stable(pwdata) && $stable(pstrb)))
    else begin
      failures++;
      $error("APB signals changed between SETUP and ACCESS");
    end

  assert property (@(posedge clk) disable iff (!arst_n)
    (psel && !pwrite) |-> (pstrb == '0))
    else begin
      failures++;
      $error("pstrb is not zero on an APB read");
    end

  assert property (@(posedge clk) !arst_n |-> (!issue_ready && !resp_valid))
    else begin
      failures++;
      $error("issue_ready or resp_valid high during reset");
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned half_period  = 50,
  parameter int unsigned reset_cycles = 16
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // release on a falling edge so no flop sees reset and clock change together
  initial begin
    arst_n = 1'b1;
    #(half_period / 2);
    arst_n = 1'b0;   // falls after time zero so every flop sees the edge
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`default_nettype none

module lsu_top #(
  parameter int unsigned ram_addr_bits = 10
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               issue_valid,
  output logic               issue_ready,
  input  lsu_pkg::lsu_req_t  issue_req,
  output logic               resp_valid,
  output lsu_pkg::lsu_resp_t resp
);
  import lsu_pkg::*;

  mem_desc_t            desc;
  exec_req_t            exec;
  logic                 exec_valid;
  logic                 take;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  xlen_t                paddr;
  xlen_t                pwdata;
  logic [strb_bits-1:0] pstrb;
  xlen_t                prdata;
  logic                 pready;
  logic                 done;
  exec_req_t            done_req;
  xlen_t                done_rdata;

  // ############################
  // pipeline
  // ############################

  lsu_decode u_decode (
    .mem_op (issue_req.mem_op),
    .desc   (desc)
  );

  lsu_execute #(
    .ram_addr_bits (ram_addr_bits)
  ) u_execute (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_req   (issue_req),
    .desc        (desc),
    .take        (take),
    .exec_valid  (exec_valid),
    .exec        (exec)
  );

  lsu_mem_access u_mem_access (
    .clk        (clk),
    .arst_n     (arst_n),
    .exec_valid (exec_valid),
    .exec       (exec),
    .take       (take),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .pstrb      (pstrb),
    .prdata     (prdata),
    .pready     (pready),
    .done       (done),
    .done_req   (done_req),
    .done_rdata (done_rdata)
  );

  lsu_result u_result (
    .clk        (clk),
    .arst_n     (arst_n),
    .done       (done),
    .done_req   (done_req),
    .done_rdata (done_rdata),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  // ############################
  // data memory
  // ############################

  data_ram_apb #(
    .ram_addr_bits (ram_addr_bits)
  ) u_data_ram (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready)
  );

endmodule

`default_nettype wire

// File: src/data_ram_apb.sv
`default_nettype none

module data_ram_apb #(
  parameter int unsigned ram_addr_bits = 10
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  lsu_pkg::xlen_t                paddr,
  input  lsu_pkg::xlen_t                pwdata,
  input  logic [lsu_pkg::strb_bits-1:0] pstrb,
  output lsu_pkg::xlen_t                prdata,
  output logic                          pready
);
  import lsu_pkg::*;

  localparam int unsigned lane_bits = $clog2(strb_bits);
  localparam int unsigned words     = 2 ** (ram_addr_bits - lane_bits);

  xlen_t                                mem [words];
  logic [ram_addr_bits-lane_bits-1:0]   word_idx;
  logic                                 wr_en;

  assign word_idx = paddr[ram_addr_bits-1:lane_bits];   // low bits pick lanes, not words
  assign pready   = 1'b1;                               // no wait states
  assign wr_en    = psel && penable && pwrite && pready;

  // read data is presented only during a read ACCESS
  assign prdata = (psel && penable && !pwrite) ? mem[word_idx] : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int w = 0; w < words; w++) begin
        mem[w] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < strb_bits; b++) begin
        if (pstrb[b]) begin
          mem[word_idx][8*b +: 8] <= pwdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_result.sv
`default_nettype none

module lsu_result (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               done,
  input  lsu_pkg::exec_req_t done_req,
  input  lsu_pkg::xlen_t     done_rdata,
  output logic               resp_valid,
  output lsu_pkg::lsu_resp_t resp
);
  import lsu_pkg::*;

  data_word_u raw;
  data_word_u lanes;
  logic       sign;
  xlen_t      load_val;
  lsu_resp_t  resp_d;
  lsu_resp_t  resp_q;
  logic       resp_valid_q;

  assign raw.dword = done_rdata;
  assign sign      = done_req.desc.sign_ext;

  // bring the addressed lane down to byte 0
  always_comb begin
    for (int i = 0; i < strb_bits; i++) begin
      lanes.bytes[i] = raw.bytes[3'(i) + done_req.addr[2:0]];
    end
  end

  always_comb begin
    case (done_req.desc.size)
      size_byte:   load_val = {{(xlen-8){sign & lanes.dword[7]}}, lanes.dword[7:0]};
      size_half:   load_val = {{(xlen-16){sign & lanes.dword[15]}}, lanes.dword[15:0]};
      size_word:   load_val = {{(xlen-32){sign & lanes.dword[31]}}, lanes.dword[31:0]};
      default:     load_val = lanes.dword;
    endcase
  end

  always_comb begin
    resp_d.rd_idx = done_req.rd_idx;
    if (done_req.fault) begin
      resp_d.kind = resp_fault;
      resp_d.data = done_req.addr;   // report where it went wrong
    end else if (done_req.desc.is_load) begin
      resp_d.kind = resp_load_data;
      resp_d.data = load_val;
    end else begin
      resp_d.kind = resp_store_ack;
      resp_d.data = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= done;
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      resp_q <= resp_d;
    end
  end

  assign resp_valid = resp_valid_q;
  assign resp       = resp_q;

endmodule

`default_nettype wire

// File: src/lsu_mem_access.sv
`default_nettype none

module lsu_mem_access (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            exec_valid,
  input  lsu_pkg::exec_req_t              exec,
  output logic                            take,
  output logic                            psel,
  output logic                            penable,
  output logic                            pwrite,
  output lsu_pkg::xlen_t                  paddr,
  output lsu_pkg::xlen_t                  pwdata,
  output logic [lsu_pkg::strb_bits-1:0]   pstrb,
  input  lsu_pkg::xlen_t                  prdata,
  input  logic                            pready,
  output logic                            done,
  output lsu_pkg::exec_req_t              done_req,
  output lsu_pkg::xlen_t                  done_rdata
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_setup  = 2'd1,
    st_access = 2'd2
  } state_e;

  state_e    state_q;
  exec_req_t req_q;
  logic      done_q;
  exec_req_t done_req_q;
  xlen_t     done_rdata_q;

  assign take = (state_q == st_idle) && exec_valid;

  // ############################
  // APB master
  // ############################

  assign psel    = (state_q != st_idle);
  assign penable = (state_q == st_access);
  assign pwrite  = req_q.desc.is_store;
  assign paddr   = req_q.addr;
  assign pwdata  = req_q.wdata;
  assign pstrb   = req_q.strb;   // cleared in execute for loads

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (take && exec.fault) begin
            done_q <= 1'b1;   // faults never reach the bus
          end else if (take) begin
            state_q <= st_setup;
          end
        end
        st_setup: state_q <= st_access;
        st_access: begin
          if (pready) begin
            state_q <= st_idle;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      req_q <= exec;
    end
    if (take && exec.fault) begin
      done_req_q   <= exec;
      done_rdata_q <= '0;
    end else if (penable && pready) begin
      done_req_q   <= req_q;
      done_rdata_q <= prdata;   // read data only valid during ACCESS
    end
  end

  assign done       = done_q;
  assign done_req   = done_req_q;
  assign done_rdata = done_rdata_q;

endmodule

`default_nettype wire

// File: src/lsu_execute.sv
`default_nettype none

module lsu_execute #(
  parameter int unsigned ram_addr_bits = 10
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               issue_valid,
  output logic               issue_ready,
  input  lsu_pkg::lsu_req_t  issue_req,
  input  lsu_pkg::mem_desc_t desc,
  input  logic               take,
  output logic               exec_valid,
  output lsu_pkg::exec_req_t exec
);
  import lsu_pkg::*;

  logic                 ready_en_q;
  logic                 exec_valid_q;
  exec_req_t            exec_q;
  exec_req_t            exec_d;
  xlen_t                addr;
  logic                 misaligned;
  logic                 out_of_range;
  logic [strb_bits-1:0] size_mask;
  data_word_u           store_src;
  data_word_u           store_lanes;

  assign addr         = issue_req.rs1_data + issue_req.imm;
  assign out_of_range = |addr[xlen-1:ram_addr_bits];
  assign store_src.dword = issue_req.rs2_data;

  always_comb begin
    misaligned = 1'b0;
    size_mask  = '0;
    case (desc.size)
      size_byte: size_mask = 8'h01;
      size_half: begin
        size_mask  = 8'h03;
        misaligned = addr[0];
      end
      size_word: begin
        size_mask  = 8'h0f;
        misaligned = |addr[1:0];
      end
      default: begin
        size_mask  = 8'hff;
        misaligned = |addr[2:0];
      end
    endcase
  end

  // rotate rs2 up so its low bytes land on the addressed lanes
  always_comb begin
    for (int i = 0; i < strb_bits; i++) begin
      store_lanes.bytes[i] = store_src.bytes[3'(i) - addr[2:0]];
    end
  end

  always_comb begin
    exec_d        = '0;
    exec_d.desc   = desc;
    exec_d.rd_idx = issue_req.rd_idx;
    exec_d.addr   = addr;
    exec_d.wdata  = store_lanes.dword;
    exec_d.strb   = desc.is_store ? (size_mask << addr[2:0]) : '0;
    exec_d.fault  = misaligned || out_of_range || !(desc.is_load || desc.is_store);
  end

  assign issue_ready = ready_en_q && (!exec_valid_q || take);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_en_q   <= 1'b0;
      exec_valid_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;   // issue side opens one cycle after reset release
      if (issue_valid && issue_ready) begin
        exec_valid_q <= 1'b1;
      end else if (take) begin
        exec_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && issue_ready) begin
      exec_q <= exec_d;
    end
  end

  assign exec_valid = exec_valid_q;
  assign exec       = exec_q;

endmodule

`default_nettype wire

// File: src/lsu_decode.sv
`default_nettype none

module lsu_decode (
  input  lsu_pkg::mem_op_e   mem_op,
  output lsu_pkg::mem_desc_t desc
);
  import lsu_pkg::*;

  logic op_half;
  logic op_word;
  logic op_double;

  // size classes do not depend on direction
  assign op_half   = (mem_op == op_lh) || (mem_op == op_lhu) || (mem_op == op_sh);
  assign op_word   = (mem_op == op_lw) || (mem_op == op_lwu) || (mem_op == op_sw);
  assign op_double = (mem_op == op_ld) || (mem_op == op_sd);

  always_comb begin
    desc = '0;   // none and unknown codes leave both directions clear

    case (mem_op)
      op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld: desc.is_load = 1'b1;
      op_sb, op_sh, op_sw, op_sd:                         desc.is_store = 1'b1;
      default:                                            desc.is_load = 1'b0;
    endcase

    // the size classes are one-hot and byte accesses encode as zero
    desc.size = acc_size_e'(({2{op_half}}   & size_half)
                          | ({2{op_word}}   & size_word)
                          | ({2{op_double}} & size_double));

    desc.sign_ext = (mem_op == op_lb) || (mem_op == op_lh) ||
                    (mem_op == op_lw) || (mem_op == op_ld);
  end

endmodule

`default_nettype wire

// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int unsigned xlen         = 64;
  localparam int unsigned strb_bits    = xlen / 8;
  localparam int unsigned reg_idx_bits = 5;

  typedef logic [xlen-1:0] xlen_t;

  // ############################
  // encodings
  // ############################

  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lbu  = 4'd2,
    op_lh   = 4'd3,
    op_lhu  = 4'd4,
    op_lw   = 4'd5,
    op_lwu  = 4'd6,
    op_ld   = 4'd7,
    op_sb   = 4'd8,
    op_sh   = 4'd9,
    op_sw   = 4'd10,
    op_sd   = 4'd11
  } mem_op_e;

  typedef enum logic [1:0] {
    size_byte   = 2'd0,
    size_half   = 2'd1,
    size_word   = 2'd2,
    size_double = 2'd3
  } acc_size_e;

  typedef enum logic [1:0] {
    resp_load_data = 2'd0,
    resp_store_ack = 2'd1,
    resp_fault     = 2'd2
  } resp_kind_e;

  // ############################
  // pipeline payloads
  // ############################

  typedef struct packed {
    logic      is_load;
    logic      is_store;
    acc_size_e size;
    logic      sign_ext;   // only meaningful for loads
  } mem_desc_t;

  typedef struct packed {
    mem_op_e                 mem_op;
    logic [reg_idx_bits-1:0] rd_idx;
    xlen_t                   rs1_data;
    xlen_t                   rs2_data;
    xlen_t                   imm;      // sign-extended by the issuer
  } lsu_req_t;

  typedef struct packed {
    mem_desc_t               desc;
    logic [reg_idx_bits-1:0] rd_idx;
    xlen_t                   addr;
    xlen_t                   wdata;    // already placed in its byte lanes
    logic [strb_bits-1:0]    strb;
    logic                    fault;
  } exec_req_t;

  typedef struct packed {
    resp_kind_e              kind;
    logic [reg_idx_bits-1:0] rd_idx;
    xlen_t                   data;
  } lsu_resp_t;

  // the same word seen as a doubleword or as byte lanes
  typedef union packed {
    xlen_t                           dword;
    logic [strb_bits-1:0][7:0]       bytes;
  } data_word_u;

endpackage

`default_nettype wire
